// File: verilog/route_pkg.sv
package route_pkg;

    // ==============================
    // Port limits
    // ==============================

    // Upper bound on the N parameter of the crossbar slice
    localparam int MAX_PORTS = 4;

    // Bits needed to name one port
    localparam int PORT_IDX_W = $clog2(MAX_PORTS);

    // Port number, used for tid, tdest and the mux grant
    typedef logic [PORT_IDX_W-1:0] port_idx_t;

    // ==============================
    // Arbiter states
    // ==============================

    // IDLE picks a new input, PACKET holds it until tlast
    typedef enum logic {
        ARB_IDLE,
        ARB_PACKET
    } arb_state_t;

endpackage

// File: verilog/axis_pkg.sv
package axis_pkg;

    // ==============================
    // Beat field widths
    // ==============================

    // 64-bit payload
    localparam int DATA_W = 64;

    // One enable bit per payload byte
    localparam int KEEP_W = DATA_W / 8;

    // User sideband, passed through untouched
    localparam int USER_W = 32;

    typedef logic [DATA_W-1:0] axis_data_t;
    typedef logic [KEEP_W-1:0] axis_keep_t;
    typedef logic [USER_W-1:0] axis_user_t;

    // ==============================
    // Stream beat
    // ==============================

    // Everything that travels with tvalid
    // tid names the source port once the beat has left the mux,
    // tdest names the sink port the demux steers it to
    typedef struct packed {
        axis_data_t           tdata;
        axis_keep_t           tkeep;
        logic                 tlast;
        route_pkg::port_idx_t tid;
        route_pkg::port_idx_t tdest;
        axis_user_t           tuser;
    } axis_beat_t;

endpackage

// File: verilog/axis_mux.sv
module axis_mux #(
    parameter int N = route_pkg::MAX_PORTS
) (
    input  logic                 clk,
    input  logic                 arst_n,

    // Source streams
    input  logic                 s_valid [N],
    input  axis_pkg::axis_beat_t s_beat  [N],
    output logic                 s_ready [N],

    // Merged stream
    output logic                 mid_valid,
    output axis_pkg::axis_beat_t mid_beat,
    input  logic                 mid_ready
);

    import axis_pkg::*;
    import route_pkg::*;

    // ==============================
    // Declarations
    // ==============================

    // Arbiter
    arb_state_t state_q;
    port_idx_t  last_q;
    port_idx_t  rr_pick;
    logic       rr_found;
    port_idx_t  grant;
    logic       grant_vld;

    // Transfer control
    logic       out_free;
    logic       accept;
    axis_beat_t in_beat;

    // One-entry output register
    logic       out_valid_q;
    axis_beat_t out_beat_q;

    // ==============================
    // Round-robin search
    // ==============================

    // First valid input after the last grant, wrapping at N
    always_comb begin
        int idx;
        rr_pick  = last_q;
        rr_found = 1'b0;
        for (int off = 1; off <= N; off++) begin
            idx = (int'(last_q) + off) % N;
            if (!rr_found && s_valid[idx]) begin
                rr_pick  = port_idx_t'(idx);
                rr_found = 1'b1;
            end
        end
    end

    // Locked input while inside a packet, fresh pick otherwise
    always_comb begin
        if (state_q == ARB_PACKET) begin
            grant     = last_q;
            grant_vld = 1'b1;
        end else begin
            grant     = rr_pick;
            grant_vld = rr_found;
        end
    end

    // ==============================
    // Handshake
    // ==============================

    // Register can take a beat when empty or draining this cycle
    assign out_free = !out_valid_q || mid_ready;

    assign accept = grant_vld && out_free && s_valid[grant];

    // Only the granted input sees ready
    for (genvar g = 0; g < N; g++) begin : g_ready
        assign s_ready[g] = grant_vld && out_free && (grant == port_idx_t'(g));
    end

    // Selected beat with its source stamped into tid
    always_comb begin
        in_beat     = s_beat[grant];
        in_beat.tid = grant;
    end

    // ==============================
    // Arbiter state
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ARB_IDLE;
            last_q  <= '0;
        end else if (accept) begin
            last_q <= grant;
            // Release the lock on the last beat of the packet
            if (in_beat.tlast) begin
                state_q <= ARB_IDLE;
            end else begin
                state_q <= ARB_PACKET;
            end
        end
    end

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q <= accept;
        end
    end

    // Refills in the same cycle it drains, holds while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            out_beat_q <= in_beat;
        end
    end

    assign mid_valid = out_valid_q;
    assign mid_beat  = out_beat_q;

endmodule

// File: verilog/axis_demux.sv
module axis_demux #(
    parameter int N = route_pkg::MAX_PORTS
) (
    // Merged stream
    input  logic                 mid_valid,
    input  axis_pkg::axis_beat_t mid_beat,
    output logic                 mid_ready,

    // Sink streams
    output logic                 m_valid [N],
    output axis_pkg::axis_beat_t m_beat  [N],
    input  logic                 m_ready [N]
);

    import route_pkg::*;

    // ==============================
    // Destination decode
    // ==============================

    // Sink addressed by the current beat
    port_idx_t sel;

    assign sel = mid_beat.tdest;

    // One-hot valid, payload broadcast to every sink
    for (genvar g = 0; g < N; g++) begin : g_port
        assign m_valid[g] = mid_valid && (sel == port_idx_t'(g));
        assign m_beat[g]  = mid_beat;
    end

    // ==============================
    // Ready return
    // ==============================

    // tdest at or beyond N matches no port, so the beat is
    // taken and dropped and the stream keeps moving
    always_comb begin
        mid_ready = 1'b1;
        for (int k = 0; k < N; k++) begin
            if (sel == port_idx_t'(k)) begin
                mid_ready = m_ready[k];
            end
        end
    end

endmodule

// File: verilog/axis_mux_demux.sv
module axis_mux_demux #(
    parameter int N = route_pkg::MAX_PORTS
) (
    input  logic                 clk,
    input  logic                 arst_n,

    // Source side
    input  logic                 s_valid [N],
    input  axis_pkg::axis_beat_t s_beat  [N],
    output logic                 s_ready [N],

    // Sink side
    output logic                 m_valid [N],
    output axis_pkg::axis_beat_t m_beat  [N],
    input  logic                 m_ready [N]
);

    import axis_pkg::*;

    // ==============================
    // Internal stream
    // ==============================

    logic       mid_valid;
    axis_beat_t mid_beat;
    logic       mid_ready;

    // Packet-locked merge, one cycle of latency
    axis_mux #(
        .N (N)
    ) u_mux (
        .clk       (clk),
        .arst_n    (arst_n),
        .s_valid   (s_valid),
        .s_beat    (s_beat),
        .s_ready   (s_ready),
        .mid_valid (mid_valid),
        .mid_beat  (mid_beat),
        .mid_ready (mid_ready)
    );

    // Combinational split by tdest
    axis_demux #(
        .N (N)
    ) u_demux (
        .mid_valid (mid_valid),
        .mid_beat  (mid_beat),
        .mid_ready (mid_ready),
        .m_valid   (m_valid),
        .m_beat    (m_beat),
        .m_ready   (m_ready)
    );

endmodule

// File: verif/axis_mux_demux_assertions.sv
module axis_mux_demux_assertions #(
    parameter int N = route_pkg::MAX_PORTS
) (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 mid_valid,
    input axis_pkg::axis_beat_t mid_beat,
    input logic                 mid_ready,
    input logic                 m_valid [N],
    input logic                 m_ready [N]
);

    import route_pkg::*;

    // Failed assertions so far, read by the testbench
    int unsigned err_count = 0;

    logic [N-1:0] m_valid_vec;
    logic         pkt_open;
    port_idx_t    pkt_tid;

    always_comb begin
        for (int k = 0; k < N; k++) begin
            m_valid_vec[k] = m_valid[k];
        end
    end

    // Packet in progress on the internal stream
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_open <= 1'b0;
            pkt_tid  <= '0;
        end else if (mid_valid && mid_ready) begin
            pkt_open <= !mid_beat.tlast;
            pkt_tid  <= mid_beat.tid;
        end
    end

    // ==============================
    // Stability and packet integrity
    // ==============================

    mid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mid_valid && !mid_ready |=> mid_valid && $stable(mid_beat))
        else begin
            err_count++;
            $error("internal stream changed while stalled");
        end

    // Source stays locked until tlast
    tid_locked: assert property (@(posedge clk) disable iff (!arst_n)
        mid_valid && pkt_open |-> mid_beat.tid == pkt_tid)
        else begin
            err_count++;
            $error("tid changed inside a packet");
        end

    // ==============================
    // Routing
    // ==============================

    sink_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(m_valid_vec))
        else begin
            err_count++;
            $error("more than one sink valid");
        end

    drop_ready: assert property (@(posedge clk) disable iff (!arst_n)
        mid_valid && mid_beat.tdest >= N |-> mid_ready)
        else begin
            err_count++;
            $error("out-of-range beat not accepted");
        end

    // A stalled sink keeps its valid until it takes the beat
    for (genvar k = 0; k < N; k++) begin : g_sink
        sink_hold: assert property (@(posedge clk) disable iff (!arst_n)
            m_valid[k] && !m_ready[k] |=> m_valid[k])
            else begin
                err_count++;
                $error("sink %0d dropped valid while stalled", k);
            end
    end

endmodule

bind axis_mux_demux axis_mux_demux_assertions #(
    .N (N)
) u_checks (
    .clk       (clk),
    .arst_n    (arst_n),
    .mid_valid (mid_valid),
    .mid_beat  (mid_beat),
    .mid_ready (mid_ready),
    .m_valid   (m_valid),
    .m_ready   (m_ready)
);

// File: verif/axis_mux_demux_tb.sv
module axis_mux_demux_tb;

    import axis_pkg::*;
    import route_pkg::*;

    localparam int N = 3;
    // About three times the beats of all tests, stalls included
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clk;
    logic       arst_n;
    logic       s_valid [N];
    axis_beat_t s_beat  [N];
    logic       s_ready [N];
    logic       m_valid [N];
    axis_beat_t m_beat  [N];
    logic       m_ready [N];

    integer      seed = 32'h0eb9c070;
    int          cycles = 0;
    logic        stall_en = 1'b0;
    int          test_errs = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int unsigned asrt_base = 0;
    string       test_name = "reset";

    // Beats per sink, split by source
    int rcv_cnt [N][MAX_PORTS];
    int exp_cnt [N][MAX_PORTS];

    // Beats still in flight, one queue per source in send order
    axis_beat_t sent_q [N][$];

    axis_mux_demux #(
        .N (N)
    ) u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_beat  (s_beat),
        .s_ready (s_ready),
        .m_valid (m_valid),
        .m_beat  (m_beat),
        .m_ready (m_ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int lim);
        rand_below = ($random(seed) & 32'h7fff_ffff) % lim;
    endfunction

    // Sink back-pressure, about half the cycles when enabled
    always @(posedge clk) begin
        for (int k = 0; k < N; k++) begin
            m_ready[k] <= stall_en ? (rand_below(2) == 0) : 1'b1;
        end
    end

    // Beat at a sink against the oldest beat its source sent
    task automatic check_beat(input int sink, input axis_beat_t got);
        axis_beat_t want;
        if (got.tid >= N || sent_q[got.tid].size() == 0) begin
            $display("%s: sink %0d got a beat that no source sent", test_name, sink);
            test_errs++;
        end else begin
            want = sent_q[got.tid].pop_front();
            if (got !== want) begin
                $display("[FAIL] %s: sink %0d beat expected %h, actual %h",
                         test_name, sink, want, got);
                test_errs++;
            end
        end
    endtask

    // Handshake seen at negedge completes on the next rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            for (int k = 0; k < N; k++) begin
                if (m_valid[k] && m_ready[k]) begin
                    rcv_cnt[k][m_beat[k].tid]++;
                    check_beat(k, m_beat[k]);
                end
            end
        end
    end

    // ==============================
    // Stimulus tasks
    // ==============================

    // Entered on a rising edge, returns on the edge of the last transfer
    task automatic send_packet(input int port, input int dest, input int len);
        axis_beat_t beat;
        axis_beat_t want;
        for (int i = 0; i < len; i++) begin
            beat.tdata = {$random(seed), $random(seed)};
            beat.tkeep = '1;
            beat.tlast = (i == len - 1);
            beat.tid   = '0;
            beat.tdest = port_idx_t'(dest);
            beat.tuser = $random(seed);
            // Sink sees the source index in tid
            want     = beat;
            want.tid = port_idx_t'(port);
            if (dest < N) sent_q[port].push_back(want);
            s_valid[port] <= 1'b1;
            s_beat[port]  <= beat;
            @(negedge clk);
            while (!s_ready[port]) @(negedge clk);
            @(posedge clk);
        end
        s_valid[port] <= 1'b0;
        if (dest < N) exp_cnt[dest][port] += len;
    endtask

    // Negative dest picks a random sink per packet
    task automatic send_stream(input int port, input int npkt, input int dest);
        int d;
        for (int p = 0; p < npkt; p++) begin
            d = (dest < 0) ? rand_below(N) : dest;
            send_packet(port, d, 1 + rand_below(8));
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (u_dut.mid_valid) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = test_errs;
        for (int d = 0; d < N; d++) begin
            sent_q[d].delete();
            for (int s = 0; s < MAX_PORTS; s++) begin
                if (rcv_cnt[d][s] != exp_cnt[d][s]) begin
                    $display("[FAIL] %s: sink %0d from source %0d expected %0d, actual %0d",
                             name, d, s, exp_cnt[d][s], rcv_cnt[d][s]);
                    errs++;
                end
                rcv_cnt[d][s] = 0;
                exp_cnt[d][s] = 0;
            end
        end
        if (u_dut.u_checks.err_count != asrt_base) begin
            $display("%s: stream assertions failed %0d times", name,
                     u_dut.u_checks.err_count - asrt_base);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
        test_errs = 0;
        asrt_base = u_dut.u_checks.err_count;
        @(posedge clk);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        arst_n = 1'b0;
        for (int k = 0; k < N; k++) begin
            s_valid[k] = 1'b0;
            s_beat[k]  = '0;
            m_ready[k] = 1'b1;
            for (int s = 0; s < MAX_PORTS; s++) begin
                rcv_cnt[k][s] = 0;
                exp_cnt[k][s] = 0;
            end
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // Idle after reset, nothing may reach a sink
        repeat (6) begin
            @(negedge clk);
            for (int k = 0; k < N; k++) begin
                if (m_valid[k] !== 1'b0) begin
                    $display("[FAIL] reset: m_valid[%0d] expected 0, actual %b", k, m_valid[k]);
                    test_errs++;
                end
            end
        end
        finish_test(test_name);

        test_name = "single_packet";
        for (int p = 0; p < N; p++) begin
            send_stream(p, 1, p);
        end
        wait_drained();
        finish_test(test_name);

        test_name = "contention";
        fork
            send_stream(0, 4, 2);
            send_stream(1, 4, 0);
            send_stream(2, 4, 1);
        join
        wait_drained();
        finish_test(test_name);

        test_name = "back_pressure";
        stall_en <= 1'b1;
        fork
            send_stream(0, 20, -1);
            send_stream(1, 20, -1);
            send_stream(2, 20, -1);
        join
        wait_drained();
        stall_en = 1'b0;
        finish_test(test_name);

        // tdest 3 is dropped, the packet behind it must still arrive
        test_name = "out_of_range";
        send_stream(0, 1, 3);
        send_stream(0, 1, 0);
        wait_drained();
        finish_test(test_name);

        $display("summary: %0d ok, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/route_pkg.sv
verilog/axis_pkg.sv
verilog/axis_mux.sv
verilog/axis_demux.sv
verilog/axis_mux_demux.sv
verif/axis_mux_demux_assertions.sv
verif/axis_mux_demux_tb.sv
